// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module fft_tb -f fft_top.f \
		--Mdir obj_dir -o fft_sim
	./obj_dir/fft_sim | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== fft_top.f ====
+incdir+include
+incdir+sim
verilog/fft_pkg.sv
verilog/fft_twiddle_generator.sv
verilog/fft_crossbar.sv
verilog/fft_butterfly.sv
verilog/fft_stage.sv
verilog/fft_top.sv
sim/fft_tb.sv

// ==== include/fft_cfg.svh ====
`ifndef FFT_CFG_SVH
`define FFT_CFG_SVH

// ======================================================================
// Fixed-point format
// ======================================================================

// Width of one real or imaginary part.
`define FFT_BIT_WIDTH 16

// Fraction bits in each part.
`define FFT_DECIMAL_PT 8

// ======================================================================
// Transform size
// ======================================================================

// Lanes per frame.
// Must be a power of two, 4 or more.
`define FFT_N_SAMPLES 8

// log2 of FFT_N_SAMPLES, one stage per bit.
`define FFT_N_STAGES 3

`endif

// ==== sim/fft_model.svh ====
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// ======================================================================
// Reference radix-2 DIT FFT in the same fixed-point format
// ======================================================================

typedef sample_t frame_t [`FFT_N_SAMPLES];

localparam real pi = 3.14159265358979323846;

// Scale to fixed point, half rounds away from zero.
function automatic sample_t round_twiddle(real v);
  real mag;
  mag = $floor((v < 0.0 ? -v : v) * real'(1 << `FFT_DECIMAL_PT) + 0.5);
  return (v < 0.0) ? sample_t'(-$rtoi(mag)) : sample_t'($rtoi(mag));
endfunction

// Full product, then arithmetic shift.
function automatic sample_t fixed_mul(sample_t x, sample_t w);
  int p;
  p = int'(x) * int'(w);
  return sample_t'(p >>> `FFT_DECIMAL_PT);
endfunction

function automatic void reference_fft(input frame_t xr, input frame_t xi,
                                      output frame_t yr, output frame_t yi);
  int rev;
  int span;
  int hi;
  int k;
  real ang;
  sample_t wr, wi, tr, ti, ur, ui;
  for (int i = 0; i < `FFT_N_SAMPLES; i++) begin
    rev = 0;
    for (int s = 0; s < `FFT_N_STAGES; s++) begin
      if (((i >> s) & 1) == 1) rev = rev | (1 << (`FFT_N_STAGES - 1 - s));
    end
    yr[i] = xr[rev];  // Bit-reversed load.
    yi[i] = xi[rev];
  end
  for (int s = 0; s < `FFT_N_STAGES; s++) begin
    span = 1 << s;
    for (int lo = 0; lo < `FFT_N_SAMPLES; lo++) begin
      if ((lo & span) == 0) begin
        hi = lo + span;
        k = (lo % span) * `FFT_N_SAMPLES / (2 * span);
        ang = 2.0 * pi * real'(k) / real'(`FFT_N_SAMPLES);
        wr = round_twiddle($cos(ang));
        wi = round_twiddle(-$sin(ang));
        tr = fixed_mul(yr[hi], wr) - fixed_mul(yi[hi], wi);
        ti = fixed_mul(yr[hi], wi) + fixed_mul(yi[hi], wr);
        ur = yr[lo];
        ui = yi[lo];
        yr[lo] = ur + tr;
        yi[lo] = ui + ti;
        yr[hi] = ur - tr;
        yi[hi] = ui - ti;
      end
    end
  end
endfunction

`endif

// ==== sim/fft_tb.sv ====
`include "fft_cfg.svh"

module fft_tb;
  import fft_pkg::*;
  `include "fft_model.svh"

  localparam int n = `FFT_N_SAMPLES;
  localparam int frame_cycles = `FFT_N_STAGES * (`FFT_BIT_WIDTH + 3);
  localparam int cycle_limit = 30 * frame_cycles + 300;  // 30 frames plus stall margin.

  logic clk;
  logic rst;
  logic in_val, in_rdy, out_val, out_rdy;
  frame_t in_real, in_imag, out_real, out_imag;

  logic [31:0] lfsr_state = 32'h76e3d24c;
  int cycles = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  sample_t got_re[$];
  sample_t got_im[$];

  fft_top fft_top_inst (
    .clk(clk), .rst(rst),
    .in_real(in_real), .in_imag(in_imag), .in_val(in_val), .in_rdy(in_rdy),
    .out_real(out_real), .out_imag(out_imag), .out_val(out_val), .out_rdy(out_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ======================================================================
  // Collector and cycle limit
  // ======================================================================

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("ERROR: no progress after %0d cycles, the DUT stopped responding", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end else if (!rst && out_val && out_rdy) begin
      for (int i = 0; i < n; i++) begin
        got_re.push_back(out_real[i]);
        got_im.push_back(out_imag[i]);
      end
    end
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int random_bits(int width);
    int v;
    v = 0;
    for (int i = 0; i < width; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic random_frame(output frame_t xr, output frame_t xi);
    for (int i = 0; i < n; i++) begin
      xr[i] = sample_t'(random_bits(9) - 256);  // About +-1.0.
      xi[i] = sample_t'(random_bits(9) - 256);
    end
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_frame(input frame_t gr, input frame_t gi, input frame_t er,
                               input frame_t ei, input string tag);
    for (int i = 0; i < n; i++) begin
      check_value(int'(gr[i]), int'(er[i]), $sformatf("%s bin %0d real", tag, i));
      check_value(int'(gi[i]), int'(ei[i]), $sformatf("%s bin %0d imag", tag, i));
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    in_val = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    got_re.delete();
    got_im.delete();
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_frame(input frame_t xr, input frame_t xi);
    bit done;
    in_real = xr;
    in_imag = xi;
    in_val = 1'b1;
    done = 1'b0;
    while (!done) begin
      done = in_rdy;
      @(negedge clk);
    end
    in_val = 1'b0;
  endtask

  task automatic recv_frame(output frame_t gr, output frame_t gi);
    while (got_re.size() < n) @(negedge clk);
    for (int i = 0; i < n; i++) begin
      gr[i] = got_re.pop_front();
      gi[i] = got_im.pop_front();
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // ======================================================================
  // Directed tests
  // ======================================================================

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    apply_reset();
    check_value(int'(out_val), 0, "out_val after reset");
    check_value(int'(in_rdy), 1, "in_rdy after reset");
    finish_test("reset_state", e0);
  endtask

  task automatic test_impulse();
    frame_t xr, xi, gr, gi, er, ei;
    int e0;
    e0 = errors;
    xr = '{default: '0};
    xi = '{default: '0};
    xr[0] = sample_t'(1 << `FFT_DECIMAL_PT);
    send_frame(xr, xi);
    recv_frame(gr, gi);
    er = '{default: xr[0]};  // Flat spectrum.
    ei = '{default: '0};
    compare_frame(gr, gi, er, ei, "impulse");
    finish_test("impulse", e0);
  endtask

  task automatic test_dc();
    frame_t xr, xi, gr, gi, er, ei;
    int e0;
    e0 = errors;
    xr = '{default: sample_t'(32)};
    xi = '{default: '0};
    send_frame(xr, xi);
    recv_frame(gr, gi);
    reference_fft(xr, xi, er, ei);
    er[0] = sample_t'(n * 32);  // Wrapped N-fold sum.
    ei[0] = '0;
    compare_frame(gr, gi, er, ei, "dc");
    finish_test("dc", e0);
  endtask

  task automatic test_random_frames();
    frame_t xr, xi, gr, gi;
    frame_t er [20];
    frame_t ei [20];
    int e0;
    e0 = errors;
    out_rdy = 1'b1;
    for (int f = 0; f < 20; f++) begin
      random_frame(xr, xi);
      reference_fft(xr, xi, er[f], ei[f]);
      send_frame(xr, xi);
    end
    for (int f = 0; f < 20; f++) begin
      recv_frame(gr, gi);
      compare_frame(gr, gi, er[f], ei[f], $sformatf("random frame %0d", f));
    end
    finish_test("random_frames", e0);
  endtask

  task automatic test_backpressure();
    frame_t xr [5];
    frame_t xi [5];
    frame_t er [5];
    frame_t ei [5];
    frame_t gr, gi, held_r, held_i;
    bit seen_low;
    int e0;
    e0 = errors;
    seen_low = 1'b0;
    for (int f = 0; f < 5; f++) begin
      random_frame(xr[f], xi[f]);
      reference_fft(xr[f], xi[f], er[f], ei[f]);
    end
    out_rdy = 1'b0;
    fork
      for (int f = 0; f < 5; f++) send_frame(xr[f], xi[f]);
      begin
        while (!out_val) @(negedge clk);
        held_r = out_real;
        held_i = out_imag;
        repeat (frame_cycles) begin
          @(negedge clk);
          check_value(int'(out_val), 1, "out_val under back-pressure");
          compare_frame(out_real, out_imag, held_r, held_i, "held output");
          if (!in_rdy) seen_low = 1'b1;
        end
        out_rdy = 1'b1;
      end
    join
    check_value(int'(seen_low), 1, "in_rdy dropped under back-pressure");
    for (int f = 0; f < 5; f++) begin
      recv_frame(gr, gi);
      compare_frame(gr, gi, er[f], ei[f], $sformatf("stalled frame %0d", f));
    end
    finish_test("backpressure", e0);
  endtask

  task automatic test_reset_midframe();
    frame_t xr, xi, gr, gi, er, ei;
    bit seen_val;
    int e0;
    e0 = errors;
    seen_val = 1'b0;
    for (int f = 0; f < 2; f++) begin
      random_frame(xr, xi);
      send_frame(xr, xi);
    end
    repeat (3) @(negedge clk);
    apply_reset();
    repeat (frame_cycles) begin
      if (out_val) seen_val = 1'b1;
      @(negedge clk);
    end
    check_value(int'(seen_val), 0, "out_val after mid-frame reset");
    random_frame(xr, xi);
    reference_fft(xr, xi, er, ei);
    send_frame(xr, xi);
    recv_frame(gr, gi);
    compare_frame(gr, gi, er, ei, "after reset");
    finish_test("reset_midframe", e0);
  endtask

  initial begin
    rst = 1'b1;
    in_val = 1'b0;
    out_rdy = 1'b1;
    in_real = '{default: '0};
    in_imag = '{default: '0};
    test_reset_state();
    test_impulse();
    test_dc();
    test_random_frames();
    test_backpressure();
    test_reset_midframe();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/fft_butterfly.sv ====
`include "fft_cfg.svh"

module fft_butterfly #(
  parameter fft_pkg::twiddle_kind_t kind = fft_pkg::tw_general
) (
  input  logic             clk,
  input  logic             rst,

  input  fft_pkg::sample_t a_real,
  input  fft_pkg::sample_t a_imag,
  input  fft_pkg::sample_t b_real,
  input  fft_pkg::sample_t b_imag,
  input  fft_pkg::sample_t w_real,
  input  fft_pkg::sample_t w_imag,
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t c_real,
  output fft_pkg::sample_t c_imag,
  output fft_pkg::sample_t d_real,
  output fft_pkg::sample_t d_imag,
  output logic             out_val,
  input  logic             out_rdy
);
  import fft_pkg::*;

  localparam int bw = `FFT_BIT_WIDTH;
  localparam int dp = `FFT_DECIMAL_PT;
  localparam int cnt_w = $clog2(bw + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(bw);
  localparam logic [cnt_w-1:0] cnt_sign = cnt_w'(bw - 1);

  typedef logic signed [2*bw-1:0] wide_t;

  logic             busy;   // Multiply in progress.
  logic             full;   // Result held.
  logic [cnt_w-1:0] cnt;
  logic             accept;
  logic             drain;
  logic             step;
  logic             load_out;

  sample_t a_re_q, a_im_q;
  sample_t wr_q, wi_q;      // Multipliers, shifted right.
  wide_t   br_sh, bi_sh;    // Multiplicands, shifted left.
  wide_t   p_rr, p_ii, p_ri, p_ir;
  sample_t t_real, t_imag;  // W*b.
  sample_t src_re, src_im;

  // One shift-add term. The sign bit carries negative weight.
  function automatic wide_t partial(wide_t mcand, logic m_bit, logic neg);
    if (!m_bit) return '0;
    return neg ? -mcand : mcand;
  endfunction

  function automatic sample_t scale(wide_t p);
    wide_t s;
    s = p >>> dp;
    return sample_t'(s);
  endfunction

  assign in_rdy   = !busy && !full;
  assign out_val  = full;
  assign accept   = in_val && in_rdy;
  assign drain    = full && out_rdy;
  assign step     = busy && (cnt != cnt_last);
  assign load_out = (kind == tw_general) ? (busy && cnt == cnt_last) : accept;

  always_comb begin
    case (kind)
      tw_one: begin
        t_real = b_real;
        t_imag = b_imag;
      end
      tw_minus_j: begin
        t_real = b_imag;
        t_imag = -b_real;
      end
      default: begin
        t_real = scale(p_rr) - scale(p_ii);
        t_imag = scale(p_ri) + scale(p_ir);
      end
    endcase
    src_re = (kind == tw_general) ? a_re_q : a_real;
    src_im = (kind == tw_general) ? a_im_q : a_imag;
  end

  // ======================================================================
  // Control
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      full <= 1'b0;
      cnt  <= '0;
    end else begin
      if (drain) full <= 1'b0;
      if (accept && kind == tw_general) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (step) begin
        cnt <= cnt + 1'b1;
      end
      if (load_out) begin
        busy <= 1'b0;
        full <= 1'b1;
      end
    end
  end

  // ======================================================================
  // Datapath
  // ======================================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      a_re_q <= a_real;
      a_im_q <= a_imag;
      wr_q   <= w_real;
      wi_q   <= w_imag;
      br_sh  <= wide_t'(b_real);  // Sign extended.
      bi_sh  <= wide_t'(b_imag);
      p_rr   <= '0;
      p_ii   <= '0;
      p_ri   <= '0;
      p_ir   <= '0;
    end else if (step) begin
      p_rr  <= p_rr + partial(br_sh, wr_q[0], cnt == cnt_sign);
      p_ii  <= p_ii + partial(bi_sh, wi_q[0], cnt == cnt_sign);
      p_ri  <= p_ri + partial(br_sh, wi_q[0], cnt == cnt_sign);
      p_ir  <= p_ir + partial(bi_sh, wr_q[0], cnt == cnt_sign);
      br_sh <= br_sh <<< 1;
      bi_sh <= bi_sh <<< 1;
      wr_q  <= wr_q >>> 1;
      wi_q  <= wi_q >>> 1;
    end

    if (load_out) begin
      c_real <= src_re + t_real;
      c_imag <= src_im + t_imag;
      d_real <= src_re - t_real;
      d_imag <= src_im - t_imag;
    end
  end

endmodule

// ==== verilog/fft_crossbar.sv ====
`include "fft_cfg.svh"

module fft_crossbar #(
  parameter int stage = 0,
  parameter bit front = 1'b1
) (
  input  fft_pkg::sample_t in_real  [`FFT_N_SAMPLES],
  input  fft_pkg::sample_t in_imag  [`FFT_N_SAMPLES],
  input  logic             in_val   [`FFT_N_SAMPLES],
  output logic             in_rdy   [`FFT_N_SAMPLES],

  output fft_pkg::sample_t out_real [`FFT_N_SAMPLES],
  output fft_pkg::sample_t out_imag [`FFT_N_SAMPLES],
  output logic             out_val  [`FFT_N_SAMPLES],
  input  logic             out_rdy  [`FFT_N_SAMPLES]
);

  localparam int span = 1 << stage;  // Partner distance in this stage.

  for (genvar b = 0; b < `FFT_N_SAMPLES / 2; b++) begin : g_pair
    localparam int lo = (b / span) * 2 * span + (b % span);
    localparam int hi = lo + span;

    if (front) begin : g_front
      // Stage lanes to butterfly pairs.
      assign out_real[2*b]   = in_real[lo];
      assign out_imag[2*b]   = in_imag[lo];
      assign out_val[2*b]    = in_val[lo];
      assign in_rdy[lo]      = out_rdy[2*b];

      assign out_real[2*b+1] = in_real[hi];
      assign out_imag[2*b+1] = in_imag[hi];
      assign out_val[2*b+1]  = in_val[hi];
      assign in_rdy[hi]      = out_rdy[2*b+1];
    end else begin : g_back
      // Butterfly pairs back to stage lanes.
      assign out_real[lo]    = in_real[2*b];
      assign out_imag[lo]    = in_imag[2*b];
      assign out_val[lo]     = in_val[2*b];
      assign in_rdy[2*b]     = out_rdy[lo];

      assign out_real[hi]    = in_real[2*b+1];
      assign out_imag[hi]    = in_imag[2*b+1];
      assign out_val[hi]     = in_val[2*b+1];
      assign in_rdy[2*b+1]   = out_rdy[hi];
    end
  end

endmodule

// ==== verilog/fft_pkg.sv ====
`include "fft_cfg.svh"

package fft_pkg;

  typedef logic signed [`FFT_BIT_WIDTH-1:0] sample_t;  // Q(BW-DP).DP two's complement.

  typedef enum logic [1:0] {
    tw_one,      // W = 1, plain add/sub.
    tw_minus_j,  // W = -j, swap and negate.
    tw_general   // Full complex multiply.
  } twiddle_kind_t;

  // Twiddle index used by butterfly b in a given stage.
  function automatic int twiddle_index(int stage, int b);
    return (b % (1 << stage)) * (`FFT_N_SAMPLES / (1 << (stage + 1)));
  endfunction

  function automatic twiddle_kind_t twiddle_kind(int k);
    if (k == 0) return tw_one;
    if (k == `FFT_N_SAMPLES / 4) return tw_minus_j;
    return tw_general;
  endfunction

  function automatic int bit_reverse(int i);
    int r;
    r = 0;
    for (int s = 0; s < `FFT_N_STAGES; s++) begin
      r = (r << 1) | ((i >> s) & 1);
    end
    return r;
  endfunction

endpackage

// ==== verilog/fft_stage.sv ====
`include "fft_cfg.svh"

module fft_stage #(
  parameter int stage = 0
) (
  input  logic             clk,
  input  logic             rst,

  input  fft_pkg::sample_t in_real  [`FFT_N_SAMPLES],
  input  fft_pkg::sample_t in_imag  [`FFT_N_SAMPLES],
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t out_real [`FFT_N_SAMPLES],
  output fft_pkg::sample_t out_imag [`FFT_N_SAMPLES],
  output logic             out_val,
  input  logic             out_rdy
);
  import fft_pkg::*;

  localparam int n = `FFT_N_SAMPLES;

  logic    lane_in_val  [n];
  logic    lane_in_rdy  [n];
  logic    lane_out_val [n];
  logic    lane_out_rdy [n];

  sample_t bf_in_real   [n];
  sample_t bf_in_imag   [n];
  logic    bf_in_val    [n];
  logic    bf_in_rdy    [n];
  sample_t bf_out_real  [n];
  sample_t bf_out_imag  [n];
  logic    bf_out_val   [n];
  logic    bf_out_rdy   [n];

  sample_t tw_real      [n/2];
  sample_t tw_imag      [n/2];
  logic    pair_in_rdy  [n/2];
  logic    pair_out_val [n/2];

  logic [n-1:0] rdy_vec;
  logic [n-1:0] val_vec;

  // ======================================================================
  // Frame handshake, all lanes move together
  // ======================================================================

  for (genvar i = 0; i < n; i++) begin : g_lane
    assign lane_in_val[i]  = in_val;
    assign rdy_vec[i]      = lane_in_rdy[i];
    assign val_vec[i]      = lane_out_val[i];
    assign lane_out_rdy[i] = out_rdy && out_val;
  end

  assign in_rdy  = &rdy_vec;
  assign out_val = &val_vec;

  fft_crossbar #(.stage(stage), .front(1'b1)) xbar_in (
    .in_real  (in_real),
    .in_imag  (in_imag),
    .in_val   (lane_in_val),
    .in_rdy   (lane_in_rdy),
    .out_real (bf_in_real),
    .out_imag (bf_in_imag),
    .out_val  (bf_in_val),
    .out_rdy  (bf_in_rdy)
  );

  fft_twiddle_generator #(.stage(stage)) twiddle_gen (
    .twiddle_real (tw_real),
    .twiddle_imag (tw_imag)
  );

  for (genvar b = 0; b < n / 2; b++) begin : g_bf
    localparam twiddle_kind_t kind_b = twiddle_kind(twiddle_index(stage, b));

    fft_butterfly #(.kind(kind_b)) bfu (
      .clk     (clk),
      .rst     (rst),
      .a_real  (bf_in_real[2*b]),
      .a_imag  (bf_in_imag[2*b]),
      .b_real  (bf_in_real[2*b+1]),
      .b_imag  (bf_in_imag[2*b+1]),
      .w_real  (tw_real[b]),
      .w_imag  (tw_imag[b]),
      .in_val  (bf_in_val[2*b] && bf_in_val[2*b+1]),
      .in_rdy  (pair_in_rdy[b]),
      .c_real  (bf_out_real[2*b]),
      .c_imag  (bf_out_imag[2*b]),
      .d_real  (bf_out_real[2*b+1]),
      .d_imag  (bf_out_imag[2*b+1]),
      .out_val (pair_out_val[b]),
      .out_rdy (out_val && bf_out_rdy[2*b] && bf_out_rdy[2*b+1])
    );

    assign bf_in_rdy[2*b]    = pair_in_rdy[b];
    assign bf_in_rdy[2*b+1]  = pair_in_rdy[b];
    assign bf_out_val[2*b]   = pair_out_val[b];
    assign bf_out_val[2*b+1] = pair_out_val[b];
  end

  fft_crossbar #(.stage(stage), .front(1'b0)) xbar_out (
    .in_real  (bf_out_real),
    .in_imag  (bf_out_imag),
    .in_val   (bf_out_val),
    .in_rdy   (bf_out_rdy),
    .out_real (out_real),
    .out_imag (out_imag),
    .out_val  (lane_out_val),
    .out_rdy  (lane_out_rdy)
  );

endmodule

// ==== verilog/fft_top.sv ====
`include "fft_cfg.svh"

module fft_top (
  input  logic             clk,
  input  logic             rst,

  input  fft_pkg::sample_t in_real  [`FFT_N_SAMPLES],
  input  fft_pkg::sample_t in_imag  [`FFT_N_SAMPLES],
  input  logic             in_val,
  output logic             in_rdy,

  output fft_pkg::sample_t out_real [`FFT_N_SAMPLES],
  output fft_pkg::sample_t out_imag [`FFT_N_SAMPLES],
  output logic             out_val,
  input  logic             out_rdy
);
  import fft_pkg::*;

  localparam int n_st = `FFT_N_STAGES;

  // Link s feeds stage s. The last link is the result.
  sample_t link_real [n_st+1][`FFT_N_SAMPLES];
  sample_t link_imag [n_st+1][`FFT_N_SAMPLES];
  logic    link_val  [n_st+1];
  logic    link_rdy  [n_st+1];

  // ======================================================================
  // Bit-reversed input order
  // ======================================================================

  for (genvar i = 0; i < `FFT_N_SAMPLES; i++) begin : g_rev
    assign link_real[0][i] = in_real[bit_reverse(i)];
    assign link_imag[0][i] = in_imag[bit_reverse(i)];
  end

  assign link_val[0] = in_val;
  assign in_rdy      = link_rdy[0];

  for (genvar s = 0; s < n_st; s++) begin : g_stage
    fft_stage #(.stage(s)) stage_inst (
      .clk      (clk),
      .rst      (rst),
      .in_real  (link_real[s]),
      .in_imag  (link_imag[s]),
      .in_val   (link_val[s]),
      .in_rdy   (link_rdy[s]),
      .out_real (link_real[s+1]),
      .out_imag (link_imag[s+1]),
      .out_val  (link_val[s+1]),
      .out_rdy  (link_rdy[s+1])
    );
  end

  assign out_real       = link_real[n_st];
  assign out_imag       = link_imag[n_st];
  assign out_val        = link_val[n_st];
  assign link_rdy[n_st] = out_rdy;

endmodule

// ==== verilog/fft_twiddle_generator.sv ====
`include "fft_cfg.svh"

module fft_twiddle_generator #(
  parameter int stage = 0
) (
  output fft_pkg::sample_t twiddle_real [`FFT_N_SAMPLES/2],
  output fft_pkg::sample_t twiddle_imag [`FFT_N_SAMPLES/2]
);
  import fft_pkg::*;

  localparam real pi = 3.14159265358979323846;
  localparam real unit = real'(1 << `FFT_DECIMAL_PT);  // Fixed-point one.

  // Scale to fixed point, rounding half away from zero.
  function automatic sample_t to_fixed(real v);
    real s;
    s = v * unit;
    if (s >= 0.0) begin
      return sample_t'($rtoi(s + 0.5));
    end
    return sample_t'(-$rtoi(0.5 - s));
  endfunction

  // ======================================================================
  // Constant table, one entry per butterfly
  // ======================================================================

  // W_k = cos(2*pi*k/N) - j*sin(2*pi*k/N).
  for (genvar b = 0; b < `FFT_N_SAMPLES / 2; b++) begin : g_tw
    localparam int k = twiddle_index(stage, b);
    localparam real angle = 2.0 * pi * real'(k) / real'(`FFT_N_SAMPLES);
    localparam sample_t w_re = to_fixed($cos(angle));
    localparam sample_t w_im = to_fixed(-$sin(angle));

    assign twiddle_real[b] = w_re;
    assign twiddle_imag[b] = w_im;
  end

endmodule
